//--- project.f
rtl/exec_pkg.sv
rtl/exec_decode.sv
rtl/alu.sv
rtl/brcond.sv
rtl/result_queue.sv
rtl/exec_unit.sv
verification/exec_unit_checker.sv
verification/exec_unit_tb.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/exec_decode.sv
      - rtl/alu.sv
      - rtl/brcond.sv
      - rtl/result_queue.sv
      - rtl/exec_unit.sv
  - target: test
    files:
      - verification/exec_unit_checker.sv
      - verification/exec_unit_tb.sv

//--- verification/exec_unit_tb.sv
`timescale 1ns/1ns

module exec_unit_tb;
	import exec_pkg::*;

	localparam int period  = 40;
	localparam int n_total = 600; // instructions over all three phases

	logic                 clock;
	logic                 rst_n;
	logic                 flush;
	logic                 issue_valid;
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [xlen-1:0]      rs1_val;
	logic [xlen-1:0]      rs2_val;
	logic [xlen-1:0]      imm;
	logic [tag_width-1:0] tag;
	logic                 wb_ready;
	logic                 br_res_ready;
	logic                 issue_ready;
	logic                 illegal;
	logic                 wb_valid;
	logic [tag_width-1:0] wb_tag;
	logic [xlen-1:0]      wb_value;
	logic                 br_res_valid;
	logic [tag_width-1:0] br_res_tag;
	logic                 br_taken;

	logic [31:0]          lfsr_state;
	logic [tag_width-1:0] next_tag;
	logic                 ill_expect;   // pulse due after an illegal transfer
	alu_result_t          alu_q[$];     // expected wb results, issue order
	br_result_t           br_q[$];      // expected branch results
	int                   mismatch_count;
	int                   other_count;
	int                   assert_failures;
	int                   alu_checked;
	int                   br_checked;
	int                   illegal_seen;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// 0 alu, 1 branch, 2 illegal
	function automatic int classify(input logic [6:0] op, input logic [2:0] f3,
			input logic [6:0] f7);
		if (op == opcode_op)
			return (f7[0] && f3[2]) ? 2 : 0; // div and rem not supported
		if (op == opcode_op_imm)
			return 0;
		if (op == opcode_branch)
			return (f3 == 3'd2 || f3 == 3'd3) ? 2 : 1;
		return 2;
	endfunction

	// rv32im integer result
	function automatic logic [31:0] alu_model(input logic [6:0] op, input logic [2:0] f3,
			input logic [6:0] f7, input logic [31:0] a, input logic [31:0] rs2,
			input logic [31:0] im);
		logic [31:0] b;
		logic [63:0] sa;
		logic [63:0] sb;
		logic [63:0] ua;
		logic [63:0] ub;
		logic [63:0] p;
		logic [4:0]  sh;
		b  = (op == opcode_op_imm) ? im : rs2;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'b0, a};
		ub = {32'b0, b};
		sh = b[4:0];
		if (op == opcode_op && f7[0]) begin
			case (f3[1:0])
				2'd0, 2'd1: p = sa * sb; // low 64 bits of the sign extended product
				2'd2:       p = sa * ub; // mulhsu
				default:    p = ua * ub;
			endcase
			return (f3[1:0] == 2'd0) ? p[31:0] : p[63:32];
		end
		case (f3)
			3'd0: return (op == opcode_op && f7[5]) ? a - b : a + b; // no subi
			3'd1: return a << sh;
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				p = f7[5] ? sa >> sh : ua >> sh; // sign bits come in from the upper half
				return p[31:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;
		endcase
	endfunction

	// half the time an edge value
	function automatic logic [31:0] pick_operand();
		logic [31:0] v;
		if (take_bits(1) == 0) begin
			case (take_bits(2))
				0:       v = 32'h0000_0000;
				1:       v = 32'hffff_ffff;
				2:       v = 32'h8000_0000;
				default: v = 32'h7fff_ffff;
			endcase
		end else begin
			v = take_bits(32);
		end
		return v;
	endfunction

	task automatic new_instruction();
		logic [3:0]  cls;
		logic [11:0] imm12;
		cls    = take_bits(4);
		funct3 = take_bits(3);
		funct7 = 7'h00;
		if (cls < 6) begin
			opcode = opcode_op;
			case (take_bits(2))
				0: funct7 = 7'h01; // m extension, div encodings land illegal
				1: if (funct3 == 3'd0 || funct3 == 3'd5) funct7 = 7'h20;
				default: ;
			endcase
		end else if (cls < 10) begin
			opcode = opcode_op_imm;
			if (funct3 == 3'd5 && take_bits(1)) funct7 = 7'h20; // srai
		end else if (cls < 15) begin
			opcode = opcode_branch;
		end else begin
			opcode = take_bits(1) ? 7'b0000011 : 7'b1101111; // load or jal
		end
		rs1_val     = pick_operand();
		rs2_val     = (take_bits(2) == 0) ? rs1_val : pick_operand(); // equal operands now and then
		imm12       = take_bits(12);
		imm         = take_bits(1) ? {{20{imm12[11]}}, imm12} : pick_operand();
		tag         = next_tag;
		next_tag    = next_tag + 1'b1;
		issue_valid = 1'b1;
	endtask

	// valid held until taken, readies and flush random each cycle
	task automatic run_phase(input int count, input int ready_level, input bit flush_on);
		int sent;
		bit fire;
		sent = 0;
		while (sent < count) begin
			@(negedge clock);
			fire = issue_valid && issue_ready;
			if (fire) sent++;
			@(posedge clock);
			#2;
			flush        = flush_on && (take_bits(4) == 0);
			wb_ready     = !flush && (take_bits(2) < ready_level);
			br_res_ready = !flush && (take_bits(2) < ready_level);
			if (fire || !issue_valid) begin
				if (sent < count && take_bits(2) != 0)
					new_instruction();
				else
					issue_valid = 1'b0;
			end
		end
	endtask

	bind exec_unit exec_unit_checker exec_unit_checker_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.flush        (flush),
		.illegal      (illegal),
		.wb_valid     (wb_valid),
		.wb_ready     (wb_ready),
		.wb_tag       (wb_tag),
		.wb_value     (wb_value),
		.br_res_valid (br_res_valid),
		.br_res_ready (br_res_ready),
		.br_res_tag   (br_res_tag),
		.br_taken     (br_taken)
	);

	exec_unit exec_unit_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.flush        (flush),
		.issue_valid  (issue_valid),
		.opcode       (opcode),
		.funct3       (funct3),
		.funct7       (funct7),
		.rs1_val      (rs1_val),
		.rs2_val      (rs2_val),
		.imm          (imm),
		.tag          (tag),
		.wb_ready     (wb_ready),
		.br_res_ready (br_res_ready),
		.issue_ready  (issue_ready),
		.illegal      (illegal),
		.wb_valid     (wb_valid),
		.wb_tag       (wb_tag),
		.wb_value     (wb_value),
		.br_res_valid (br_res_valid),
		.br_res_tag   (br_res_tag),
		.br_taken     (br_taken)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		#(n_total * 40 * period);
		$display("watchdog expired: the run did not finish in time, DUT looks hung");
		$display("TB FAILED");
		$finish;
	end

	// inputs settle at +2, so negedge shows what the next edge will take
	always @(negedge clock) begin
		int          kind;
		int          in_flight;
		alu_result_t alu_exp;
		br_result_t  br_exp;
		if (!rst_n) begin
			ill_expect = 1'b0;
		end else begin
			kind = classify(opcode, funct3, funct7);
			if (illegal !== ill_expect) begin
				mismatch_count++;
				$display("mismatch at %0t: illegal expected %b got %b", $time, ill_expect, illegal);
			end
			if (illegal) illegal_seen++;
			ill_expect = issue_valid && issue_ready && kind == 2;
			// unit takes a fourth result only once one leaves
			if (issue_valid && kind != 2) begin
				in_flight = (kind == 0) ? alu_q.size() : br_q.size();
				if (issue_ready !== (in_flight < 3)) begin
					mismatch_count++;
					$display("mismatch at %0t: issue_ready expected %b got %b", $time,
						in_flight < 3, issue_ready);
				end
			end
			if (wb_valid && alu_q.size() == 0) begin
				other_count++;
				$display("error at %0t: ALU result tag %h with no instruction in flight",
					$time, wb_tag);
			end else if (wb_valid && wb_ready) begin
				alu_exp = alu_q.pop_front();
				alu_checked++;
				if (wb_tag !== alu_exp.tag) begin
					mismatch_count++;
					$display("mismatch at %0t: wb_tag expected %h got %h", $time,
						alu_exp.tag, wb_tag);
				end
				if (wb_value !== alu_exp.value) begin
					mismatch_count++;
					$display("mismatch at %0t: wb_value expected %h got %h", $time,
						alu_exp.value, wb_value);
				end
			end
			if (br_res_valid && br_q.size() == 0) begin
				other_count++;
				$display("error at %0t: branch result tag %h with no instruction in flight",
					$time, br_res_tag);
			end else if (br_res_valid && br_res_ready) begin
				br_exp = br_q.pop_front();
				br_checked++;
				if (br_res_tag !== br_exp.tag) begin
					mismatch_count++;
					$display("mismatch at %0t: br_res_tag expected %h got %h", $time,
						br_exp.tag, br_res_tag);
				end
				if (br_taken !== br_exp.taken) begin
					mismatch_count++;
					$display("mismatch at %0t: br_taken expected %b got %b", $time,
						br_exp.taken, br_taken);
				end
			end
			if (issue_valid && issue_ready && !flush) begin // flush cycle issue is dropped
				if (kind == 0)
					alu_q.push_back({tag,
						alu_model(opcode, funct3, funct7, rs1_val, rs2_val, imm)});
				else if (kind == 1)
					br_q.push_back({tag, branch_model(funct3, rs1_val, rs2_val)});
			end
			if (flush) begin
				alu_q.delete();
				br_q.delete();
			end
		end
	end

	initial begin
		lfsr_state      = 32'h3167;
		next_tag        = '0;
		ill_expect      = 1'b0;
		mismatch_count  = 0;
		other_count     = 0;
		assert_failures = 0;
		alu_checked     = 0;
		br_checked      = 0;
		illegal_seen    = 0;
		rst_n           = 1'b0;
		flush           = 1'b0;
		issue_valid     = 1'b0;
		opcode          = '0;
		funct3          = '0;
		funct7          = '0;
		rs1_val         = '0;
		rs2_val         = '0;
		imm             = '0;
		tag             = '0;
		wb_ready        = 1'b0;
		br_res_ready    = 1'b0;
		repeat (3) @(posedge clock);
		#2;
		rst_n = 1'b1;

		run_phase(200, 4, 1'b0); // free flowing
		run_phase(200, 1, 1'b0); // heavy back-pressure
		run_phase(200, 2, 1'b1); // back-pressure with flushes

		// drain what is left
		@(posedge clock);
		#2;
		flush        = 1'b0;
		issue_valid  = 1'b0;
		wb_ready     = 1'b1;
		br_res_ready = 1'b1;
		while (alu_q.size() != 0 || br_q.size() != 0) @(negedge clock);
		repeat (4) @(negedge clock); // stray outputs would show here

		assert_failures = exec_unit_inst.exec_unit_checker_inst.failures;
		$display("alu %0d br %0d illegal %0d, errors mismatch %0d other %0d assert %0d",
			alu_checked, br_checked, illegal_seen, mismatch_count, other_count,
			assert_failures);
		if (mismatch_count == 0 && other_count == 0 && assert_failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- verification/exec_unit_checker.sv
`timescale 1ns/1ns

module exec_unit_checker (
	input logic                            clock,
	input logic                            rst_n,
	input logic                            flush,
	input logic                            illegal,
	input logic                            wb_valid,
	input logic                            wb_ready,
	input logic [exec_pkg::tag_width-1:0]  wb_tag,
	input logic [exec_pkg::xlen-1:0]       wb_value,
	input logic                            br_res_valid,
	input logic                            br_res_ready,
	input logic [exec_pkg::tag_width-1:0]  br_res_tag,
	input logic                            br_taken
);

	int failures; // failed assertions so far

	initial failures = 0;

	// stalled result holds, a flush may drop it
	wb_held: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid && !wb_ready && !flush |=> wb_valid && $stable(wb_tag) && $stable(wb_value))
		else begin
			$error("wb result changed or vanished while stalled");
			failures++;
		end

	br_held: assert property (@(posedge clock) disable iff (!rst_n)
		br_res_valid && !br_res_ready && !flush |=>
			br_res_valid && $stable(br_res_tag) && $stable(br_taken))
		else begin
			$error("branch result changed or vanished while stalled");
			failures++;
		end

	// first cycle out of reset is quiet
	reset_quiet: assert property (@(posedge clock)
		$rose(rst_n) |-> !wb_valid && !br_res_valid && !illegal)
		else begin
			$error("output valid or illegal high right after reset");
			failures++;
		end

	illegal_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		illegal |=> !illegal)
		else begin
			$error("illegal held for two cycles");
			failures++;
		end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            flush,
	input  logic                            issue_valid,
	input  logic [6:0]                      opcode,
	input  logic [2:0]                      funct3,
	input  logic [6:0]                      funct7,
	input  logic [exec_pkg::xlen-1:0]       rs1_val,
	input  logic [exec_pkg::xlen-1:0]       rs2_val,
	input  logic [exec_pkg::xlen-1:0]       imm,
	input  logic [exec_pkg::tag_width-1:0]  tag,
	input  logic                            wb_ready,
	input  logic                            br_res_ready,
	output logic                            issue_ready,
	output logic                            illegal,
	output logic                            wb_valid,
	output logic [exec_pkg::tag_width-1:0]  wb_tag,
	output logic [exec_pkg::xlen-1:0]       wb_value,
	output logic                            br_res_valid,
	output logic [exec_pkg::tag_width-1:0]  br_res_tag,
	output logic                            br_taken
);
	import exec_pkg::*;

	// decoder to alu
	logic                 alu_valid;
	logic                 alu_ready;
	alu_func_t            alu_func;
	logic [xlen-1:0]      alu_opa;
	logic [xlen-1:0]      alu_opb;
	logic [tag_width-1:0] alu_tag;

	// decoder to brcond
	logic                 br_valid;
	logic                 br_ready;
	br_func_t             br_func;
	logic [xlen-1:0]      br_rs1;
	logic [xlen-1:0]      br_rs2;
	logic [tag_width-1:0] br_tag;

	// units to queues
	logic                 alu_out_valid;
	logic                 alu_out_ready;
	alu_result_t          alu_out_result;
	logic                 br_out_valid;
	logic                 br_out_ready;
	br_result_t           br_out_result;

	alu_result_t          wb_data;
	br_result_t           br_res_data;

	exec_decode exec_decode_inst (
		.clock       (clock),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.opcode      (opcode),
		.funct3      (funct3),
		.funct7      (funct7),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.imm         (imm),
		.tag         (tag),
		.alu_ready   (alu_ready),
		.br_ready    (br_ready),
		.issue_ready (issue_ready),
		.alu_valid   (alu_valid),
		.alu_func    (alu_func),
		.alu_opa     (alu_opa),
		.alu_opb     (alu_opb),
		.alu_tag     (alu_tag),
		.br_valid    (br_valid),
		.br_func     (br_func),
		.br_rs1      (br_rs1),
		.br_rs2      (br_rs2),
		.br_tag      (br_tag),
		.illegal     (illegal)
	);

	alu alu_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.in_valid   (alu_valid),
		.func       (alu_func),
		.opa        (alu_opa),
		.opb        (alu_opb),
		.tag        (alu_tag),
		.in_ready   (alu_ready),
		.out_valid  (alu_out_valid),
		.out_result (alu_out_result),
		.out_ready  (alu_out_ready)
	);

	brcond brcond_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.in_valid   (br_valid),
		.func       (br_func),
		.rs1        (br_rs1),
		.rs2        (br_rs2),
		.tag        (br_tag),
		.out_ready  (br_out_ready),
		.in_ready   (br_ready),
		.out_valid  (br_out_valid),
		.out_result (br_out_result)
	);

	result_queue #(.payload_t(alu_result_t)) alu_queue_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (alu_out_valid),
		.in_data   (alu_out_result),
		.out_ready (wb_ready),
		.in_ready  (alu_out_ready),
		.out_valid (wb_valid),
		.out_data  (wb_data)
	);

	result_queue #(.payload_t(br_result_t)) br_queue_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (br_out_valid),
		.in_data   (br_out_result),
		.out_ready (br_res_ready),
		.in_ready  (br_out_ready),
		.out_valid (br_res_valid),
		.out_data  (br_res_data)
	);

	// payload structs out as loose ports
	assign wb_tag     = wb_data.tag;
	assign wb_value   = wb_data.value;
	assign br_res_tag = br_res_data.tag;
	assign br_taken   = br_res_data.taken;

endmodule

//--- rtl/result_queue.sv
`timescale 1ns/1ns

module result_queue #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	input  logic     out_ready,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data
);

	payload_t   mem [2]; // two slots, used as a ring
	logic       rd_ptr;
	logic       wr_ptr;
	logic [1:0] count;   // 0 to 2 entries held
	logic       push;
	logic       pop;

	assign in_ready  = (count != 2'd2);
	assign out_valid = (count != 2'd0); // registered state only, no fall-through
	assign out_data  = mem[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop  = out_valid & out_ready;

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			rd_ptr <= 1'b0;
			wr_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			count <= count + 2'(push) - 2'(pop); // both at once keeps the count
		end
	end

	// slot contents only matter while counted
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

//--- rtl/brcond.sv
`timescale 1ns/1ns

module brcond (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            flush,
	input  logic                            in_valid,
	input  exec_pkg::br_func_t              func,
	input  logic [exec_pkg::xlen-1:0]       rs1,
	input  logic [exec_pkg::xlen-1:0]       rs2,
	input  logic [exec_pkg::tag_width-1:0]  tag,
	input  logic                            out_ready,
	output logic                            in_ready,
	output logic                            out_valid,
	output exec_pkg::br_result_t            out_result
);
	import exec_pkg::*;

	logic signed [xlen-1:0] signed_rs1;
	logic signed [xlen-1:0] signed_rs2;
	logic                   taken;

	assign signed_rs1 = rs1;
	assign signed_rs2 = rs2;

	always_comb begin
		case (func)
			br_beq:  taken = rs1 == rs2;
			br_bne:  taken = rs1 != rs2;
			br_blt:  taken = signed_rs1 < signed_rs2;
			br_bge:  taken = signed_rs1 >= signed_rs2;
			br_bltu: taken = rs1 < rs2;  // unsigned compare
			br_bgeu: taken = rs1 >= rs2;
			default: taken = 1'b0;
		endcase
	end

	assign in_ready = ~out_valid | out_ready; // same stall rule as the alu

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_result.tag   <= tag;
			out_result.taken <= taken;
		end
	end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            flush,
	input  logic                            in_valid,
	input  exec_pkg::alu_func_t             func,
	input  logic [exec_pkg::xlen-1:0]       opa,
	input  logic [exec_pkg::xlen-1:0]       opb,
	input  logic [exec_pkg::tag_width-1:0]  tag,
	output logic                            in_ready,
	output logic                            out_valid,
	output exec_pkg::alu_result_t           out_result,
	input  logic                            out_ready
);
	import exec_pkg::*;

	logic signed [xlen-1:0]   signed_opa;
	logic signed [xlen-1:0]   signed_opb;
	logic signed [xlen:0]     zext_opb;     // opb as a positive signed value
	logic signed [2*xlen-1:0] signed_mul;
	logic signed [2*xlen-1:0] mixed_mul;    // mulhsu
	logic        [2*xlen-1:0] unsigned_mul;
	logic        [4:0]        shamt;
	logic        [xlen-1:0]   value;

	assign signed_opa   = opa;
	assign signed_opb   = opb;
	assign zext_opb     = {1'b0, opb};
	assign signed_mul   = signed_opa * signed_opb;
	assign mixed_mul    = signed_opa * zext_opb;
	assign unsigned_mul = opa * opb; // widened by the 64 bit target
	assign shamt        = opb[4:0];

	always_comb begin
		case (func)
			alu_add:    value = opa + opb;
			alu_sub:    value = opa - opb;
			alu_and:    value = opa & opb;
			alu_or:     value = opa | opb;
			alu_xor:    value = opa ^ opb;
			alu_slt:    value = {{(xlen-1){1'b0}}, signed_opa < signed_opb};
			alu_sltu:   value = {{(xlen-1){1'b0}}, opa < opb};
			alu_sll:    value = opa << shamt;
			alu_srl:    value = opa >> shamt;
			alu_sra:    value = $unsigned(signed_opa >>> shamt); // sign fill
			alu_mul:    value = signed_mul[xlen-1:0];
			alu_mulh:   value = signed_mul[2*xlen-1:xlen];
			alu_mulhsu: value = mixed_mul[2*xlen-1:xlen];
			alu_mulhu:  value = unsigned_mul[2*xlen-1:xlen];
			default:    value = '0;
		endcase
	end

	// stage frees up when empty or when its result leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_result.tag   <= tag;
			out_result.value <= value;
		end
	end

endmodule

//--- rtl/exec_decode.sv
`timescale 1ns/1ns

module exec_decode (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            issue_valid,
	input  logic [6:0]                      opcode,
	input  logic [2:0]                      funct3,
	input  logic [6:0]                      funct7,
	input  logic [exec_pkg::xlen-1:0]       rs1_val,
	input  logic [exec_pkg::xlen-1:0]       rs2_val,
	input  logic [exec_pkg::xlen-1:0]       imm,
	input  logic [exec_pkg::tag_width-1:0]  tag,
	input  logic                            alu_ready,
	input  logic                            br_ready,
	output logic                            issue_ready,
	output logic                            alu_valid,
	output exec_pkg::alu_func_t             alu_func,
	output logic [exec_pkg::xlen-1:0]       alu_opa,
	output logic [exec_pkg::xlen-1:0]       alu_opb,
	output logic [exec_pkg::tag_width-1:0]  alu_tag,
	output logic                            br_valid,
	output exec_pkg::br_func_t              br_func,
	output logic [exec_pkg::xlen-1:0]       br_rs1,
	output logic [exec_pkg::xlen-1:0]       br_rs2,
	output logic [exec_pkg::tag_width-1:0]  br_tag,
	output logic                            illegal
);
	import exec_pkg::*;

	logic alu_sel; // goes to the alu
	logic br_sel;  // goes to brcond
	logic use_imm; // op-imm, operand b from the immediate

	// base integer ops, alt is funct7[5] where it means sub or sra
	function automatic alu_func_t base_func(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  base_func = alt ? alu_sub : alu_add;
			3'b001:  base_func = alu_sll;
			3'b010:  base_func = alu_slt;
			3'b011:  base_func = alu_sltu;
			3'b100:  base_func = alu_xor;
			3'b101:  base_func = alt ? alu_sra : alu_srl;
			3'b110:  base_func = alu_or;
			default: base_func = alu_and;
		endcase
	endfunction

	always_comb begin
		alu_sel  = 1'b0;
		br_sel   = 1'b0;
		use_imm  = 1'b0;
		alu_func = alu_add;
		case (opcode)
			opcode_op: begin
				if (funct7[0]) begin // rv32m
					alu_sel = ~funct3[2]; // div and rem fall through as illegal
					case (funct3[1:0])
						2'b00:   alu_func = alu_mul;
						2'b01:   alu_func = alu_mulh;
						2'b10:   alu_func = alu_mulhsu;
						default: alu_func = alu_mulhu;
					endcase
				end else begin
					alu_sel  = 1'b1;
					alu_func = base_func(funct3, funct7[5]);
				end
			end
			opcode_op_imm: begin
				alu_sel  = 1'b1;
				use_imm  = 1'b1;
				// no subi, funct7 only picks srai over srli
				alu_func = base_func(funct3, funct7[5] & (funct3 == 3'b101));
			end
			opcode_branch: br_sel = (funct3[2:1] != 2'b01); // funct3 2 and 3 unused
			default: ;
		endcase
	end

	// illegal ops are taken at most every other cycle so the pulse stays single
	assign issue_ready = alu_sel ? alu_ready : (br_sel ? br_ready : ~illegal);

	assign alu_valid = issue_valid & alu_sel;
	assign alu_opa   = rs1_val;
	assign alu_opb   = use_imm ? imm : rs2_val;
	assign alu_tag   = tag;

	assign br_valid = issue_valid & br_sel;
	assign br_func  = br_func_t'(funct3);
	assign br_rs1   = rs1_val;
	assign br_rs2   = rs2_val;
	assign br_tag   = tag;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			illegal <= 1'b0;
		end else begin
			illegal <= issue_valid & issue_ready & ~alu_sel & ~br_sel; // dropped here
		end
	end

endmodule

//--- rtl/exec_pkg.sv
package exec_pkg;

	localparam int xlen      = 32;
	localparam int tag_width = 4;

	// rv32 major opcodes handled by the execute stage
	localparam logic [6:0] opcode_op     = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;
	localparam logic [6:0] opcode_branch = 7'b1100011;

	// alu functions, base integer ops then the rv32m multiplies
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_mul,
		alu_mulh,
		alu_mulhsu,
		alu_mulhu
	} alu_func_t;

	// encoded as funct3, so the decoder casts straight across
	typedef enum logic [2:0] {
		br_beq  = 3'd0,
		br_bne  = 3'd1,
		br_blt  = 3'd4,
		br_bge  = 3'd5,
		br_bltu = 3'd6,
		br_bgeu = 3'd7
	} br_func_t;

	typedef struct packed {
		logic [tag_width-1:0] tag;
		logic [xlen-1:0]      value;
	} alu_result_t; // 36 bits

	typedef struct packed {
		logic [tag_width-1:0] tag;
		logic                 taken;
	} br_result_t; // 5 bits

endpackage
